// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_breakout
FLIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= TB PASSED

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== ball_paddle.sv ====
// Keys are active low and sampled only on step; with both keys held the paddle stays put
`timescale 1ns/1ps
`include "breakout_defs.svh"

module ball_paddle (
	input logic CLOCK_50,
	input logic rst,
	input logic round_start,
	input logic step,
	input logic bounce,
	input logic key_left,
	input logic key_right,
	output breakout_pkg::coord_t ball_x,
	output breakout_pkg::coord_t ball_y,
	output breakout_pkg::coord_t paddle_x,
	output logic missed
);

	import breakout_pkg::*;

	logic dir_right, dir_down;
	coord_t nx, ny; // Ball position after this step
	logic on_paddle;

	assign nx = dir_right ? ball_x + 8'd1 : ball_x - 8'd1;
	assign ny = dir_down ? ball_y + 8'd1 : ball_y - 8'd1;

	// Falling ball just above the paddle row and over it
	assign on_paddle = dir_down && (ny == coord_t'(`PAD_Y - 1)) &&
		(nx >= paddle_x) && (nx < paddle_x + coord_t'(`PAD_W));

	assign missed = (ball_y == coord_t'(`SCR_H - 1));

	always_ff @(posedge CLOCK_50) begin
		if (rst || round_start) begin
			paddle_x <= coord_t'(`PAD_X0);
			ball_x <= coord_t'(`BALL_X0);
			ball_y <= coord_t'(`BALL_Y0);
			dir_right <= 1'b1;
			dir_down <= 1'b0; // Up and right
		end else if (step) begin
			if (!key_right && key_left && paddle_x < coord_t'(`SCR_W - `PAD_W))
				paddle_x <= paddle_x + 8'd1;
			else if (!key_left && key_right && paddle_x != 8'd0)
				paddle_x <= paddle_x - 8'd1;

			ball_x <= nx;
			ball_y <= ny;
			if (nx == 8'd0 || nx == coord_t'(`SCR_W - 1))
				dir_right <= ~dir_right; // Side walls
			if (ny == 8'd0 || on_paddle)
				dir_down <= ~dir_down;
		end else if (bounce) begin
			dir_down <= ~dir_down; // Block hit
		end
	end

endmodule

// ==== block_field.sv ====
// sel_idx must stay below BLK_NUM; the ceiling is unbounded and only the floor check ends the game
`timescale 1ns/1ps
`include "breakout_defs.svh"

module block_field (
	input logic CLOCK_50,
	input logic rst,
	input logic new_game,
	input logic ceil_drop,
	input logic check,
	input breakout_pkg::blk_idx_t sel_idx,
	input breakout_pkg::coord_t ball_x,
	input breakout_pkg::coord_t ball_y,
	output breakout_pkg::coord_t blk_x,
	output breakout_pkg::coord_t blk_y,
	output breakout_pkg::colour_t blk_colour,
	output logic hit,
	output logic all_cleared,
	output logic floor_reached
);

	import breakout_pkg::*;

	logic [`BLK_NUM-1:0] alive;
	coord_t ceil;
	logic [1:0] row;
	logic [2:0] col;
	logic sel_alive;

	// Index to row and column
	always_comb begin
		if (sel_idx >= 5'd14)
			row = 2'd2;
		else if (sel_idx >= 5'd7)
			row = 2'd1;
		else
			row = 2'd0;
		col = 3'(sel_idx - 5'd7 * 5'(row));
	end

	assign sel_alive = (sel_idx < blk_idx_t'(`BLK_NUM)) && alive[sel_idx];
	assign blk_x = coord_t'(`BLK_X0 + `BLK_XSTEP * col + row); // Rows step right by one
	assign blk_y = coord_t'(`BLK_Y0 + `BLK_YSTEP * row) + ceil;

	always_comb begin
		case (row)
			2'd0: blk_colour = `COL_RED;
			2'd1: blk_colour = `COL_YELLOW;
			default: blk_colour = `COL_BLUE;
		endcase
		if (!sel_alive)
			blk_colour = `COL_BLACK; // Dead blocks are drawn as holes
	end

	// Ball row within one of the block's top row, column inside the block
	assign hit = check && sel_alive &&
		(ball_y + 8'd1 >= blk_y) && (ball_y <= blk_y + 8'd1) &&
		(ball_x >= blk_x) && (ball_x < blk_x + coord_t'(`BLK_W));

	assign all_cleared = ~|alive;

	always_comb begin
		floor_reached = 1'b0;
		for (int r = 0; r < `BLK_ROWS; r++) begin
			if (|alive[r*`BLK_COLS +: `BLK_COLS] &&
				(`BLK_Y0 + `BLK_YSTEP * r + ceil + `BLK_H > `FLOOR_LINE))
				floor_reached = 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst || new_game) begin
			alive <= '1;
			ceil <= '0;
		end else begin
			if (hit)
				alive[sel_idx] <= 1'b0;
			if (ceil_drop)
				ceil <= ceil + coord_t'(`CEIL_STEP);
		end
	end

endmodule

// ==== breakout_assert.sv ====
// Bound to rect_drawer; checks the pixel stream and draw handshake and reports only through $error
`timescale 1ns/1ps
`include "breakout_defs.svh"

module breakout_assert (
	input logic CLOCK_50,
	input logic rst,
	input logic draw_start,
	input logic plot,
	input logic draw_done,
	input breakout_pkg::coord_t pix_x,
	input breakout_pkg::coord_t pix_y
);

	import breakout_pkg::*;

	plot_in_screen: assert property (@(posedge CLOCK_50) disable iff (rst)
		plot |-> (pix_x < coord_t'(`SCR_W)) && (pix_y < coord_t'(`SCR_H)))
		else $error("Pixel written outside the screen");

	done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (rst)
		draw_done |=> !draw_done)
		else $error("draw_done held for more than one cycle");

	// Output is quiet through reset
	plot_low_in_reset: assert property (@(posedge CLOCK_50) rst |=> !plot)
		else $error("plot high while reset is asserted");

	start_when_idle: assert property (@(posedge CLOCK_50) disable iff (rst)
		draw_start |-> !plot)
		else $error("draw_start arrived while a rectangle was being drawn");

endmodule

bind rect_drawer breakout_assert breakout_assert_i (.*);

// ==== breakout_defs.svh ====
// All geometry must fit 8-bit coordinates; the default frame period assumes a 50 MHz clock
`ifndef BREAKOUT_DEFS_SVH
`define BREAKOUT_DEFS_SVH

// Screen
`define SCR_W 160
`define SCR_H 120

// Paddle and ball
`define PAD_W 16
`define PAD_H 2
`define PAD_Y 110
`define PAD_X0 72
`define BALL_X0 80
`define BALL_Y0 108

// Block field, x = BLK_X0 + BLK_XSTEP*col + row
`define BLK_W 8
`define BLK_H 2
`define BLK_COLS 7
`define BLK_ROWS 3
`define BLK_NUM 21
`define BLK_X0 10
`define BLK_XSTEP 20
`define BLK_Y0 20
`define BLK_YSTEP 5
`define CEIL_STEP 7
`define FLOOR_LINE 108

// 3-bit RGB
`define COL_BLACK 3'b000
`define COL_WHITE 3'b111
`define COL_RED 3'b100
`define COL_YELLOW 3'b110
`define COL_BLUE 3'b001
`define COL_GREEN 3'b010

`define FRAME_CYCLES_DEF 833333 // About 60 frames per second

`endif

// ==== breakout_pkg.sv ====
// Widths assume a 160x120 screen, 3-bit colour, an 8-bit score and at most 32 blocks
package breakout_pkg;

	typedef logic [7:0] coord_t; // Screen x or y
	typedef logic [2:0] colour_t; // R, G, B from high to low bit
	typedef logic [7:0] score_t;
	typedef logic [4:0] blk_idx_t;
	typedef logic [6:0] seg_t; // Active low, segment a in bit 0

	// Game sequencer
	typedef enum logic [4:0] {
		S_CLEAR, S_INIT_PAD, S_INIT_BALL,
		S_IDLE,
		S_BLK_CHECK, S_BLK_DRAW,
		S_PAD_ERASE, S_PAD_UPD, S_PAD_DRAW,
		S_BALL_ERASE, S_BALL_STEP, S_BALL_DRAW,
		S_WIN_CHECK,
		S_CEIL, S_FLOOR_CHECK,
		S_END_FILL, S_DONE
	} game_state_t;

endpackage

// ==== breakout_top.sv ====
// The frame buffer must take one pixel per cycle; keys are active low and already synchronised
`timescale 1ns/1ps
`include "breakout_defs.svh"

module breakout_top #(
	parameter int FRAME_CYCLES = `FRAME_CYCLES_DEF
) (
	input logic CLOCK_50,
	input logic rst,
	input logic key_left,
	input logic key_right,
	input logic key_start,
	output breakout_pkg::coord_t pix_x,
	output breakout_pkg::coord_t pix_y,
	output breakout_pkg::colour_t pix_colour,
	output logic plot,
	output breakout_pkg::seg_t hex0,
	output breakout_pkg::seg_t hex1,
	output breakout_pkg::seg_t hex4,
	output breakout_pkg::seg_t hex5
);

	import breakout_pkg::*;

	logic frame_tick;

	// Draw handshake
	logic draw_start, draw_done;
	coord_t draw_x, draw_y, draw_w, draw_h;
	colour_t draw_colour;

	// Block access
	blk_idx_t sel_idx;
	logic check, hit;
	coord_t blk_x, blk_y;
	colour_t blk_colour;
	logic all_cleared, floor_reached;

	// Game strobes
	logic new_game, round_start, step, ceil_drop, game_end;
	coord_t ball_x, ball_y, paddle_x;
	logic missed;

	frame_timer #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) frame_timer_i (.*);

	rect_drawer rect_drawer_i (.*);

	block_field block_field_i (.*);

	ball_paddle ball_paddle_i (
		.bounce(hit), // Block hit flips the vertical direction
		.*
	);

	score_keeper score_keeper_i (
		.add_point(hit),
		.*
	);

	game_fsm game_fsm_i (.*);

endmodule

// ==== frame_timer.sv ====
// FRAME_CYCLES must be at least 2; the first tick comes FRAME_CYCLES cycles after reset
`timescale 1ns/1ps
`include "breakout_defs.svh"

module frame_timer #(
	parameter int FRAME_CYCLES = `FRAME_CYCLES_DEF
) (
	input logic CLOCK_50,
	input logic rst,
	output logic frame_tick
);

	localparam int CNT_W = $clog2(FRAME_CYCLES + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			count <= CNT_W'(FRAME_CYCLES - 1);
			frame_tick <= 1'b0;
		end else if (count == '0) begin
			count <= CNT_W'(FRAME_CYCLES - 1); // Reload
			frame_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			frame_tick <= 1'b0;
		end
	end

endmodule

// ==== game_fsm.sv ====
// Assumes the rectangle drawer accepts a start whenever it is idle; frame ticks outside idle are dropped
`timescale 1ns/1ps
`include "breakout_defs.svh"

module game_fsm (
	input logic CLOCK_50,
	input logic rst,
	input logic frame_tick,
	input logic key_start,
	input logic draw_done,
	input logic hit,
	input logic missed,
	input logic all_cleared,
	input logic floor_reached,
	input breakout_pkg::coord_t blk_x,
	input breakout_pkg::coord_t blk_y,
	input breakout_pkg::coord_t ball_x,
	input breakout_pkg::coord_t ball_y,
	input breakout_pkg::coord_t paddle_x,
	input breakout_pkg::colour_t blk_colour,
	output logic draw_start,
	output breakout_pkg::coord_t draw_x,
	output breakout_pkg::coord_t draw_y,
	output breakout_pkg::coord_t draw_w,
	output breakout_pkg::coord_t draw_h,
	output breakout_pkg::colour_t draw_colour,
	output breakout_pkg::blk_idx_t sel_idx,
	output logic check,
	output logic new_game,
	output logic round_start,
	output logic step,
	output logic ceil_drop,
	output logic game_end
);

	import breakout_pkg::*;

	game_state_t state;
	logic drawing; // A rectangle is in flight
	logic is_draw;
	logic pass_hit; // Some block died in this pass
	coord_t old_x, old_y; // Ball before the step, for the erase
	colour_t fill_colour;

	assign is_draw = state inside {S_CLEAR, S_INIT_PAD, S_INIT_BALL, S_BLK_DRAW,
		S_PAD_ERASE, S_PAD_DRAW, S_BALL_ERASE, S_BALL_DRAW, S_END_FILL};
	assign draw_start = is_draw && !drawing;

	assign check = (state == S_BLK_CHECK);
	assign step = (state == S_PAD_UPD); // Moves paddle and ball together
	assign ceil_drop = (state == S_CEIL);
	assign new_game = (state == S_DONE) && !key_start;
	assign round_start = new_game || ((state == S_FLOOR_CHECK) && !floor_reached);
	assign game_end = ((state == S_FLOOR_CHECK) && floor_reached) ||
		((state == S_WIN_CHECK) && pass_hit && all_cleared);

	// Rectangle for the current state, full screen unless overridden
	always_comb begin
		draw_x = '0;
		draw_y = '0;
		draw_w = coord_t'(`SCR_W);
		draw_h = coord_t'(`SCR_H);
		draw_colour = `COL_BLACK;
		case (state)
			S_END_FILL: draw_colour = fill_colour;
			S_INIT_PAD, S_PAD_ERASE, S_PAD_DRAW: begin
				draw_x = paddle_x;
				draw_y = coord_t'(`PAD_Y);
				draw_w = coord_t'(`PAD_W);
				draw_h = coord_t'(`PAD_H);
				draw_colour = (state == S_PAD_ERASE) ? `COL_BLACK : `COL_WHITE;
			end
			S_INIT_BALL, S_BALL_DRAW, S_BALL_ERASE: begin
				draw_x = (state == S_BALL_ERASE) ? old_x : ball_x;
				draw_y = (state == S_BALL_ERASE) ? old_y : ball_y;
				draw_w = 8'd1;
				draw_h = 8'd1;
				draw_colour = (state == S_BALL_ERASE) ? `COL_BLACK : `COL_WHITE;
			end
			S_BLK_DRAW: begin
				draw_x = blk_x;
				draw_y = blk_y;
				draw_w = coord_t'(`BLK_W);
				draw_h = coord_t'(`BLK_H);
				draw_colour = blk_colour;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= S_CLEAR;
			drawing <= 1'b0;
			sel_idx <= '0;
			pass_hit <= 1'b0;
		end else begin
			if (draw_start)
				drawing <= 1'b1;
			else if (draw_done)
				drawing <= 1'b0;

			case (state)
				S_CLEAR: if (draw_done) state <= S_INIT_PAD;
				S_INIT_PAD: if (draw_done) state <= S_INIT_BALL;
				S_INIT_BALL: if (draw_done) state <= S_IDLE;
				S_IDLE: begin
					if (frame_tick) begin
						sel_idx <= '0;
						pass_hit <= 1'b0;
						state <= S_BLK_CHECK;
					end
				end
				S_BLK_CHECK: begin
					if (hit)
						pass_hit <= 1'b1;
					state <= S_BLK_DRAW;
				end
				S_BLK_DRAW: begin
					if (draw_done) begin
						if (sel_idx == blk_idx_t'(`BLK_NUM - 1)) begin
							state <= S_PAD_ERASE;
						end else begin
							sel_idx <= sel_idx + 5'd1;
							state <= S_BLK_CHECK;
						end
					end
				end
				S_PAD_ERASE: if (draw_done) state <= S_PAD_UPD;
				S_PAD_UPD: state <= S_PAD_DRAW;
				S_PAD_DRAW: if (draw_done) state <= S_BALL_ERASE;
				S_BALL_ERASE: if (draw_done) state <= S_BALL_STEP;
				S_BALL_STEP: state <= missed ? S_CEIL : S_BALL_DRAW;
				S_BALL_DRAW: if (draw_done) state <= S_WIN_CHECK;
				S_WIN_CHECK: state <= game_end ? S_END_FILL : S_IDLE;
				S_CEIL: state <= S_FLOOR_CHECK;
				S_FLOOR_CHECK: state <= floor_reached ? S_END_FILL : S_CLEAR;
				S_END_FILL: if (draw_done) state <= S_DONE;
				S_DONE: if (!key_start) state <= S_CLEAR;
				default: state <= S_CLEAR;
			endcase
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (step) begin
			old_x <= ball_x;
			old_y <= ball_y;
		end
		if (game_end)
			fill_colour <= (state == S_WIN_CHECK) ? `COL_GREEN : `COL_RED;
	end

endmodule

// ==== rect_drawer.sv ====
// Width and height must be at least 1; a start while plot is high restarts the rectangle
`timescale 1ns/1ps

module rect_drawer (
	input logic CLOCK_50,
	input logic rst,
	input logic draw_start,
	input breakout_pkg::coord_t draw_x,
	input breakout_pkg::coord_t draw_y,
	input breakout_pkg::coord_t draw_w,
	input breakout_pkg::coord_t draw_h,
	input breakout_pkg::colour_t draw_colour,
	output breakout_pkg::coord_t pix_x,
	output breakout_pkg::coord_t pix_y,
	output breakout_pkg::colour_t pix_colour,
	output logic plot,
	output logic draw_done
);

	import breakout_pkg::*;

	coord_t org_x, org_y;
	coord_t rect_w, rect_h;
	coord_t col, row; // Offset of the pixel on the output
	logic last_pix;

	assign last_pix = (col == rect_w - 8'd1) && (row == rect_h - 8'd1);
	assign pix_x = org_x + col;
	assign pix_y = org_y + row;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			plot <= 1'b0;
			draw_done <= 1'b0;
		end else begin
			draw_done <= 1'b0;
			if (draw_start) begin
				plot <= 1'b1;
			end else if (plot && last_pix) begin
				plot <= 1'b0;
				draw_done <= 1'b1; // One cycle after the last pixel
			end
		end
	end

	// Raster walk, left to right then down
	always_ff @(posedge CLOCK_50) begin
		if (draw_start) begin
			org_x <= draw_x;
			org_y <= draw_y;
			rect_w <= draw_w;
			rect_h <= draw_h;
			pix_colour <= draw_colour;
			col <= '0;
			row <= '0;
		end else if (plot) begin
			if (col == rect_w - 8'd1) begin
				col <= '0;
				row <= row + 8'd1;
			end else begin
				col <= col + 8'd1;
			end
		end
	end

endmodule

// ==== score_keeper.sv ====
// Score wraps after 255 points; digits show hexadecimal, not decimal
`timescale 1ns/1ps

module score_keeper (
	input logic CLOCK_50,
	input logic rst,
	input logic new_game,
	input logic add_point,
	input logic game_end,
	output breakout_pkg::seg_t hex0,
	output breakout_pkg::seg_t hex1,
	output breakout_pkg::seg_t hex4,
	output breakout_pkg::seg_t hex5
);

	import breakout_pkg::*;

	score_t score, hi_score;

	function automatic seg_t hex_seg(input logic [3:0] digit);
		case (digit)
			4'h0: hex_seg = 7'b100_0000;
			4'h1: hex_seg = 7'b111_1001;
			4'h2: hex_seg = 7'b010_0100;
			4'h3: hex_seg = 7'b011_0000;
			4'h4: hex_seg = 7'b001_1001;
			4'h5: hex_seg = 7'b001_0010;
			4'h6: hex_seg = 7'b000_0010;
			4'h7: hex_seg = 7'b111_1000;
			4'h8: hex_seg = 7'b000_0000;
			4'h9: hex_seg = 7'b001_1000;
			4'hA: hex_seg = 7'b000_1000;
			4'hB: hex_seg = 7'b000_0011;
			4'hC: hex_seg = 7'b100_0110;
			4'hD: hex_seg = 7'b010_0001;
			4'hE: hex_seg = 7'b000_0110;
			default: hex_seg = 7'b000_1110; // F
		endcase
	endfunction

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			score <= '0;
			hi_score <= '0;
		end else begin
			if (new_game)
				score <= '0; // High score survives a restart
			else if (add_point)
				score <= score + 8'd1;
			if (game_end && score > hi_score)
				hi_score <= score;
		end
	end

	assign hex0 = hex_seg(score[3:0]);
	assign hex1 = hex_seg(score[7:4]);
	assign hex4 = hex_seg(hi_score[3:0]);
	assign hex5 = hex_seg(hi_score[7:4]);

endmodule

// ==== tb_breakout.sv ====
// Plays one game with a short frame period until the end fill, then checks a restart; Verilator needs --timing
`timescale 1ns/1ps
`include "breakout_defs.svh"

`define CYCLE_LIMIT (14 * (19200 + 300 * 600))

module tb_breakout;

	import breakout_pkg::*;

	typedef struct packed {
		coord_t x0;
		coord_t y0;
		coord_t x1;
		coord_t y1;
		colour_t col;
		logic mixed;
		int n;
	} burst_t;

	logic CLOCK_50, rst, key_left, key_right, key_start;
	coord_t pix_x, pix_y;
	colour_t pix_colour;
	logic plot;
	seg_t hex0, hex1, hex4, hex5;

	burst_t bursts[$];
	burst_t cur;
	logic in_burst = 1'b0;
	logic cover_on = 1'b1; // Count writes during the first clear only
	int touch [0:159][0:119];
	colour_t shadow [0:159][0:119];
	int chk [1:6];
	int err [1:6];
	int cycles = 0;

	// Game model kept from the pixel stream
	int n_fill = 0, exp_ceil = 0, exp_score = 0, exp_hi = 0;
	int exp_pad = `PAD_X0, last_pad = `PAD_X0, blk_ptr = 0, n_pass = 0, hold = 0;
	int bx = 0, by = 0;
	logic ball_valid = 1'b0, go_left = 1'b1, ended = 1'b0, done = 1'b0;
	logic alive [0:20];

	breakout_top #(.FRAME_CYCLES(600)) breakout_top_i (.*);

	always #20 CLOCK_50 = ~CLOCK_50;

	function automatic int block_x_at(input int i);
		return `BLK_X0 + `BLK_XSTEP * (i % `BLK_COLS) + i / `BLK_COLS;
	endfunction

	function automatic int block_y_at(input int i, input int ceil);
		return `BLK_Y0 + `BLK_YSTEP * (i / `BLK_COLS) + ceil;
	endfunction

	function automatic colour_t row_colour(input int i);
		case (i / `BLK_COLS)
			0: return `COL_RED;
			1: return `COL_YELLOW;
			default: return `COL_BLUE;
		endcase
	endfunction

	// Keys are active low, both held means no move
	function automatic int next_paddle(input int x, input logic kl, input logic kr);
		if (!kr && kl)
			return (x < `SCR_W - `PAD_W) ? x + 1 : x;
		if (!kl && kr)
			return (x > 0) ? x - 1 : x;
		return x;
	endfunction

	function automatic seg_t seg_pattern(input int d);
		logic [6:0] on; // Lit segments, g down to a
		case (d & 15)
			0: on = 7'h3F;
			1: on = 7'h06;
			2: on = 7'h5B;
			3: on = 7'h4F;
			4: on = 7'h66;
			5: on = 7'h6D;
			6: on = 7'h7D;
			7: on = 7'h07;
			8: on = 7'h7F;
			9: on = 7'h67;
			10: on = 7'h77;
			11: on = 7'h7C;
			12: on = 7'h39;
			13: on = 7'h5E;
			14: on = 7'h79;
			default: on = 7'h71;
		endcase
		return ~on;
	endfunction

	function automatic logic floor_hit(input int ceil);
		logic any = 1'b0;
		for (int i = 0; i < `BLK_NUM; i++)
			if (alive[i] && block_y_at(i, ceil) + `BLK_H > `FLOOR_LINE)
				any = 1'b1;
		return any;
	endfunction

	task automatic expect_true(input int t, input logic ok, input string msg);
		chk[t]++;
		assert (ok) else begin
			err[t]++;
			$display("MISMATCH at %0t ns: test %0d, %s", $time, t, msg);
		end
	endtask

	task automatic report_test(input int t, input string name);
		$display("test %0d %s finished: %0d checks, %0d errors", t, name, chk[t], err[t]);
	endtask

	// Group consecutive plot cycles into rectangles
	always @(negedge CLOCK_50) begin
		if (plot) begin
			if (!in_burst) begin
				cur.x0 = pix_x;
				cur.y0 = pix_y;
				cur.col = pix_colour;
				cur.mixed = 1'b0;
				cur.n = 0;
			end
			in_burst = 1'b1;
			cur.x1 = pix_x;
			cur.y1 = pix_y;
			cur.n++;
			if (pix_colour != cur.col)
				cur.mixed = 1'b1;
			if (pix_x < `SCR_W && pix_y < `SCR_H) begin
				shadow[pix_x][pix_y] = pix_colour;
				if (cover_on)
					touch[pix_x][pix_y]++;
			end
		end else if (in_burst) begin
			bursts.push_back(cur);
			in_burst = 1'b0;
		end
	end

	always @(posedge CLOCK_50) begin
		cycles++;
		if (cycles >= `CYCLE_LIMIT) begin
			$display("Timeout: the game did not end within %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic fill_burst(input burst_t b);
		int bad = 0;
		if (b.col == `COL_BLACK) begin
			if (n_fill == 0) begin
				for (int x = 0; x < `SCR_W; x++)
					for (int y = 0; y < `SCR_H; y++)
						if (touch[x][y] != 1 || shadow[x][y] != `COL_BLACK)
							bad++;
				expect_true(1, bad == 0,
					$sformatf("%0d pixels not cleared exactly once", bad));
				cover_on = 1'b0;
			end else if (ended) begin
				expect_true(6, hex0 == seg_pattern(0) && hex1 == seg_pattern(0),
					"score not 0 after restart");
				expect_true(6, hex4 == seg_pattern(exp_hi) && hex5 == seg_pattern(exp_hi >> 4),
					"high score lost on restart");
				report_test(6, "end fill and restart");
				done = 1'b1;
			end else begin
				exp_ceil += `CEIL_STEP; // Missed ball, new round
			end
			exp_pad = `PAD_X0;
			ball_valid = 1'b0;
			blk_ptr = 0;
		end else begin
			if (b.col == `COL_GREEN)
				expect_true(6, exp_score == `BLK_NUM, "green fill with blocks left");
			else
				expect_true(6, b.col == `COL_RED && floor_hit(exp_ceil + `CEIL_STEP),
					"red fill without a block below the floor line");
			if (exp_score > exp_hi)
				exp_hi = exp_score;
			expect_true(6, hex4 == seg_pattern(exp_hi) && hex5 == seg_pattern(exp_hi >> 4),
				$sformatf("high score display, expected %0d", exp_hi));
			report_test(3, "paddle movement");
			report_test(4, "ball steps");
			report_test(5, "score and ceiling");
			ended = 1'b1;
			repeat (2) @(posedge CLOCK_50);
			key_start <= 1'b0;
			repeat (3) @(posedge CLOCK_50);
			key_start <= 1'b1;
		end
		n_fill++;
	endtask

	// The initial paddle draw already counts as one pass
	task automatic block_burst(input burst_t b);
		int i;
		int t;
		i = blk_ptr;
		t = (n_pass == 1) ? 2 : 5;
		expect_true(t, b.x0 == block_x_at(i) && b.y0 == block_y_at(i, exp_ceil),
			$sformatf("block %0d at (%0d,%0d)", i, b.x0, b.y0));
		if (alive[i] && b.col == `COL_BLACK) begin
			alive[i] = 1'b0;
			exp_score++;
		end else begin
			expect_true(t, b.col == (alive[i] ? row_colour(i) : `COL_BLACK),
				$sformatf("block %0d colour %0d", i, b.col));
		end
		expect_true(5, hex0 == seg_pattern(exp_score) && hex1 == seg_pattern(exp_score >> 4),
			$sformatf("score display, expected %0d", exp_score));
		if (i == `BLK_NUM - 1 && n_pass == 1)
			report_test(2, "block field");
		blk_ptr = (i + 1) % `BLK_NUM;
	endtask

	task automatic paddle_burst(input burst_t b);
		expect_true(3, b.y0 == `PAD_Y, "paddle row");
		if (b.col == `COL_BLACK) begin
			expect_true(3, b.x0 == last_pad, "paddle erase away from the paddle");
			return;
		end
		expect_true(3, b.col == `COL_WHITE && b.x0 == exp_pad,
			$sformatf("paddle at %0d, expected %0d", b.x0, exp_pad));
		last_pad = b.x0;
		if (hold == 0) begin
			hold = $urandom_range(1, 3);
			go_left = (n_pass < 90) || (bx >= b.x0 + `PAD_W / 2); // Run from the ball
		end
		hold--;
		n_pass++;
		exp_pad = next_paddle(b.x0, !go_left, go_left);
		@(posedge CLOCK_50);
		key_left <= !go_left;
		key_right <= go_left;
	endtask

	task automatic ball_burst(input burst_t b);
		if (b.col == `COL_BLACK) begin
			expect_true(4, ball_valid && b.x0 == bx && b.y0 == by, "ball erase position");
			return;
		end
		if (!ball_valid)
			expect_true(4, b.x0 == `BALL_X0 && b.y0 == `BALL_Y0, "ball start position");
		else
			expect_true(4, (b.x0 == bx + 1 || b.x0 == bx - 1) &&
				(b.y0 == by + 1 || b.y0 == by - 1),
				$sformatf("ball jump (%0d,%0d) to (%0d,%0d)", bx, by, b.x0, b.y0));
		if (n_fill == 1 && !ball_valid && n_pass == 1)
			report_test(1, "reset clear and first draw");
		bx = b.x0;
		by = b.y0;
		ball_valid = 1'b1;
	endtask

	initial begin
		burst_t b;
		int w;
		int h;
		int total_chk = 0;
		int total_err = 0;
		CLOCK_50 = 1'b0;
		rst = 1'b1;
		key_left = 1'b1;
		key_right = 1'b1;
		key_start = 1'b1;
		void'($urandom(32'hd51d_cbf3));
		foreach (alive[i])
			alive[i] = 1'b1;
		repeat (4) @(posedge CLOCK_50);
		rst <= 1'b0;
		while (!done) begin
			wait (bursts.size() > 0);
			b = bursts.pop_front();
			w = int'(b.x1) - int'(b.x0) + 1;
			h = int'(b.y1) - int'(b.y0) + 1;
			expect_true(1, !b.mixed && b.n == w * h,
				"rectangle not filled in one colour");
			if (w == `SCR_W && h == `SCR_H) begin
				fill_burst(b);
			end else if (w == `BLK_W && h == `BLK_H) begin
				block_burst(b);
			end else if (w == `PAD_W && h == `PAD_H) begin
				paddle_burst(b);
			end else if (w == 1 && h == 1) begin
				ball_burst(b);
			end else begin
				expect_true(1, 1'b0, $sformatf("unexpected %0dx%0d rectangle", w, h));
			end
		end
		for (int t = 1; t <= 6; t++) begin
			total_chk += chk[t];
			total_err += err[t];
		end
		$display("Checks: %0d, errors: %0d", total_chk, total_err);
		if (total_err == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
breakout_pkg.sv
frame_timer.sv
rect_drawer.sv
block_field.sv
ball_paddle.sv
score_keeper.sv
game_fsm.sv
breakout_top.sv
breakout_assert.sv
tb_breakout.sv
